// File: source/renderPkg.sv
/* Widths, raster constants and colours shared by the renderer.
   Raster timing assumes an 800 x 525 scan with a 640 x 480 visible area. */
`default_nettype none

package renderPkg;

	typedef logic [11:0] worldCoord;
	typedef logic [9:0] screenCoord;
	typedef logic [12:0] tileIndex;
	typedef logic [9:0] texelAddr;
	typedef logic [12:0] spriteAddr;
	typedef logic [23:0] rgbColor;
	typedef logic [7:0] channel;

	typedef enum logic [1:0] {North, South, East, West} facing;
	typedef enum logic [1:0] {Void, Grass, Water, Sand} terrainKind;
	typedef enum logic {FetchOne, FetchTwo} viewPhase;

	// Raster
	localparam int LineLength = 800;
	localparam int FrameLines = 525;
	localparam int LeadX = 2;
	localparam int LeadY = 1;
	localparam int HalfViewX = 320;
	localparam int HalfViewY = 240;
	localparam int BlankStart = 640;
	localparam int BlankEnd = 799;

	// Map border in world pixels, one tile of margin on each side
	localparam int MapLow = 32;
	localparam int MapHighX = 3168;
	localparam int MapHighY = 2368;
	localparam int TileSize = 32;
	localparam int MapColumns = 100;

	localparam int SpriteSize = 75;
	localparam int SpriteLowX = 283;
	localparam int SpriteLowY = 203;
	localparam int SpriteCut = 16;

	localparam rgbColor TransparentKey = 24'hff00d2;
	localparam rgbColor GrassColor = 24'h20a040;
	localparam rgbColor WaterColor = 24'h2040c0;
	localparam rgbColor SandColor = 24'hc0b060;
	localparam rgbColor NorthColor = 24'hf0f0f0;
	localparam rgbColor SouthColor = 24'hf04020;
	localparam rgbColor EastColor = 24'h20f040;
	localparam rgbColor WestColor = 24'h4020f0;

endpackage

`default_nettype wire

// File: source/fetchIf.sv
/* One view's memory request, driven combinationally by its mapper.
   Plain levels, no handshake. */
`timescale 1ns/1ps
`default_nettype none

interface fetchIf;

	renderPkg::tileIndex tileIdx;
	renderPkg::texelAddr texel;
	renderPkg::spriteAddr spriteIdx;
	renderPkg::facing dir;
	logic inMap;
	logic inPlayer;

	modport mapper (
		output tileIdx, texel, spriteIdx, dir, inMap, inPlayer
	);

	modport sequencer (
		input tileIdx, texel, spriteIdx, dir, inMap, inPlayer
	);

endinterface

`default_nettype wire

// File: source/pixelIf.sv
/* Fetched colours and flags for one view.
   Data is only valid while capture is high. */
`timescale 1ns/1ps
`default_nettype none

interface pixelIf;

	renderPkg::rgbColor terrainColor;
	renderPkg::rgbColor spriteColor;
	logic inMap;
	logic inPlayer;
	logic capture;

	modport sequencer (
		output terrainColor, spriteColor, inMap, inPlayer, capture
	);

	modport composer (
		input terrainColor, spriteColor, inMap, inPlayer, capture
	);

endinterface

`default_nettype wire

// File: source/pixelLead.sv
/* Beam lookahead that compensates the fetch pipeline.
   Expects drawX below 800 and drawY below 525. */
`timescale 1ns/1ps
`default_nettype none

module pixelLead (
	input wire logic Clk,
	input wire logic arstN,
	input renderPkg::screenCoord drawX,
	input renderPkg::screenCoord drawY,
	output renderPkg::screenCoord leadX,
	output renderPkg::screenCoord leadY,
	output logic visible
);

	logic [10:0] sumX;
	logic [10:0] sumY;

	assign sumX = 11'(drawX) + 11'(renderPkg::LeadX);
	assign sumY = 11'(drawY) + 11'(renderPkg::LeadY);

	// Wrap to the start of the line or frame
	assign leadX = (sumX >= renderPkg::LineLength) ?
		renderPkg::screenCoord'(sumX - renderPkg::LineLength) : renderPkg::screenCoord'(sumX);
	assign leadY = (sumY >= renderPkg::FrameLines) ?
		renderPkg::screenCoord'(sumY - renderPkg::FrameLines) : renderPkg::screenCoord'(sumY);

	always_ff @(posedge Clk or negedge arstN)
	begin
		if (!arstN)
			visible <= 1'b0;
		else
			visible <= !(drawX > renderPkg::BlankStart && drawX < renderPkg::BlankEnd);
	end

	// A single subtraction only wraps correctly for a beam inside the frame
	drawInFrame: assert property (@(posedge Clk) disable iff (!arstN)
		drawX < renderPkg::LineLength && drawY < renderPkg::FrameLines);

endmodule

`default_nettype wire

// File: source/viewportMapper.sv
/* Maps the lead beam position into one player's world view.
   World arithmetic wraps at 4096, so positions left of the view fall outside the map. */
`timescale 1ns/1ps
`default_nettype none

module viewportMapper (
	input renderPkg::worldCoord playerX,
	input renderPkg::worldCoord playerY,
	input renderPkg::facing dir,
	input renderPkg::screenCoord leadX,
	input renderPkg::screenCoord leadY,
	fetchIf.mapper req
);

	renderPkg::worldCoord worldX;
	renderPkg::worldCoord worldY;
	logic inSpriteX;
	logic inSpriteY;
	logic inSprite;

	// View is centred on the player
	assign worldX = playerX - renderPkg::worldCoord'(renderPkg::HalfViewX)
		+ renderPkg::worldCoord'(leadX);
	assign worldY = playerY - renderPkg::worldCoord'(renderPkg::HalfViewY)
		+ renderPkg::worldCoord'(leadY);

	assign req.inMap = worldX >= renderPkg::MapLow && worldX < renderPkg::MapHighX
		&& worldY >= renderPkg::MapLow && worldY < renderPkg::MapHighY;

	assign req.tileIdx = renderPkg::tileIndex'((worldY / renderPkg::TileSize)
		* renderPkg::MapColumns + worldX / renderPkg::TileSize);
	assign req.texel = renderPkg::texelAddr'((worldY % renderPkg::TileSize)
		* renderPkg::TileSize + worldX % renderPkg::TileSize);

	// Sprite sits at a fixed screen position, open interval on both axes
	assign inSpriteX = leadX > renderPkg::SpriteLowX
		&& leadX < renderPkg::SpriteLowX + renderPkg::SpriteSize - 1;
	assign inSpriteY = leadY > renderPkg::SpriteLowY
		&& leadY < renderPkg::SpriteLowY + renderPkg::SpriteSize - 1;
	assign inSprite = inSpriteX && inSpriteY;

	assign req.inPlayer = inSprite;
	assign req.spriteIdx = inSprite ? renderPkg::spriteAddr'((leadY - renderPkg::SpriteLowY)
		* renderPkg::SpriteSize + (leadX - renderPkg::SpriteLowX)) : '0;
	assign req.dir = dir;

endmodule

`default_nettype wire

// File: source/viewSequencer.sv
/* Shares one set of memories between two views by alternating every clock.
   Each view gets a fresh result every second clock. */
`timescale 1ns/1ps
`default_nettype none

module viewSequencer (
	input wire logic Clk,
	input wire logic arstN,
	fetchIf.sequencer viewOne,
	fetchIf.sequencer viewTwo,
	output renderPkg::tileIndex tileIdx,
	output renderPkg::texelAddr texel,
	output renderPkg::spriteAddr spriteIdx,
	output renderPkg::facing dir,
	input renderPkg::rgbColor terrainColor,
	input renderPkg::rgbColor spriteColor,
	pixelIf.sequencer outOne,
	pixelIf.sequencer outTwo
);

	renderPkg::viewPhase phase;
	logic mapQ;
	logic playerQ;
	logic captureOne;
	logic captureTwo;

	always_ff @(posedge Clk or negedge arstN)
	begin
		if (!arstN)
		begin
			phase <= renderPkg::FetchOne;
			captureOne <= 1'b0;
			captureTwo <= 1'b0;
		end
		else
		begin
			phase <= (phase == renderPkg::FetchOne) ? renderPkg::FetchTwo : renderPkg::FetchOne;
			// Memory data for the view fetched now is valid next clock
			captureOne <= (phase == renderPkg::FetchOne);
			captureTwo <= (phase == renderPkg::FetchTwo);
		end
	end

	// Flags ride alongside the memory read
	always_ff @(posedge Clk)
	begin
		mapQ <= (phase == renderPkg::FetchOne) ? viewOne.inMap : viewTwo.inMap;
		playerQ <= (phase == renderPkg::FetchOne) ? viewOne.inPlayer : viewTwo.inPlayer;
	end

	always_comb
	begin
		case (phase)
			renderPkg::FetchOne:
			begin
				tileIdx = viewOne.tileIdx;
				texel = viewOne.texel;
				spriteIdx = viewOne.spriteIdx;
				dir = viewOne.dir;
			end
			default:
			begin
				tileIdx = viewTwo.tileIdx;
				texel = viewTwo.texel;
				spriteIdx = viewTwo.spriteIdx;
				dir = viewTwo.dir;
			end
		endcase
	end

	assign outOne.terrainColor = terrainColor;
	assign outOne.spriteColor = spriteColor;
	assign outOne.inMap = mapQ;
	assign outOne.inPlayer = playerQ;
	assign outOne.capture = captureOne;

	assign outTwo.terrainColor = terrainColor;
	assign outTwo.spriteColor = spriteColor;
	assign outTwo.inMap = mapQ;
	assign outTwo.inPlayer = playerQ;
	assign outTwo.capture = captureTwo;

	captureExclusive: assert property (@(posedge Clk) disable iff (!arstN)
		!(outOne.capture && outTwo.capture));

endmodule

`default_nettype wire

// File: source/terrainRom.sv
/* Read-only tile map and texel pattern, one clock of read latency.
   Indices past the 100 x 75 map read as Void and give black. */
`timescale 1ns/1ps
`default_nettype none

module terrainRom (
	input wire logic Clk,
	input renderPkg::tileIndex tileIdx,
	input renderPkg::texelAddr texel,
	output renderPkg::rgbColor color
);

	localparam int MapDepth = 1 << $bits(renderPkg::tileIndex);
	localparam int TexelDepth = 1 << $bits(renderPkg::texelAddr);
	localparam int MapTiles = renderPkg::MapColumns * 75;

	renderPkg::terrainKind kindMem [MapDepth];
	logic shadeMem [TexelDepth];
	renderPkg::terrainKind kindQ;
	logic shadeQ;
	renderPkg::rgbColor base;

	function automatic renderPkg::rgbColor kindColor(renderPkg::terrainKind kind);
		case (kind)
			renderPkg::Grass: return renderPkg::GrassColor;
			renderPkg::Water: return renderPkg::WaterColor;
			renderPkg::Sand: return renderPkg::SandColor;
			default: return '0;
		endcase
	endfunction

	initial
	begin
		for (int i = 0; i < MapDepth; i++)
		begin
			if (i < MapTiles)
				kindMem[i] = renderPkg::terrainKind'(
					(i % renderPkg::MapColumns + i / renderPkg::MapColumns) % 3 + 1);
			else
				kindMem[i] = renderPkg::Void;
		end
		// Checkerboard, odd texels are the darker shade
		for (int a = 0; a < TexelDepth; a++)
			shadeMem[a] = ((a % renderPkg::TileSize + a / renderPkg::TileSize) % 2) == 1;
	end

	always_ff @(posedge Clk)
	begin
		kindQ <= kindMem[tileIdx];
		shadeQ <= shadeMem[texel];
	end

	assign base = kindColor(kindQ);
	assign color = shadeQ ? ((base >> 1) & 24'h7f7f7f) : base;

endmodule

`default_nettype wire

// File: source/spriteRom.sv
/* Player sprite in four facings, 75 x 75, one clock of read latency.
   The top-left corner is cut out with the transparent key. */
`timescale 1ns/1ps
`default_nettype none

module spriteRom (
	input wire logic Clk,
	input renderPkg::spriteAddr spriteIdx,
	input renderPkg::facing dir,
	output renderPkg::rgbColor color
);

	localparam int Depth = renderPkg::SpriteSize * renderPkg::SpriteSize;

	renderPkg::rgbColor spriteMem [4][Depth];

	function automatic renderPkg::rgbColor dirColor(int d);
		case (d)
			0: return renderPkg::NorthColor;
			1: return renderPkg::SouthColor;
			2: return renderPkg::EastColor;
			default: return renderPkg::WestColor;
		endcase
	endfunction

	initial
	begin
		int row;
		int col;
		for (int d = 0; d < 4; d++)
		begin
			for (int i = 0; i < Depth; i++)
			begin
				row = i / renderPkg::SpriteSize;
				col = i % renderPkg::SpriteSize;
				if (row + col < renderPkg::SpriteCut)
					spriteMem[d][i] = renderPkg::TransparentKey;
				else
					spriteMem[d][i] = dirColor(d);
			end
		end
	end

	always_ff @(posedge Clk)
	begin
		color <= spriteMem[dir][spriteIdx];
	end

endmodule

`default_nettype wire

// File: source/pixelComposer.sv
/* Holds one view's pixel between captures and layers the sprite over the map.
   Output colour keeps 5 bits per channel. */
`timescale 1ns/1ps
`default_nettype none

module pixelComposer #(
	parameter bit BlankGate = 1'b0
) (
	input wire logic Clk,
	input wire logic arstN,
	pixelIf.composer pix,
	input wire logic visible,
	output renderPkg::channel red,
	output renderPkg::channel green,
	output renderPkg::channel blue
);

	renderPkg::rgbColor mapQ;
	renderPkg::rgbColor spriteQ;
	renderPkg::rgbColor shown;
	logic blank;

	always_ff @(posedge Clk or negedge arstN)
	begin
		if (!arstN)
		begin
			mapQ <= '0;
			spriteQ <= renderPkg::TransparentKey;
		end
		else if (pix.capture)
		begin
			mapQ <= pix.inMap ? pix.terrainColor : '0;
			spriteQ <= pix.inPlayer ? pix.spriteColor : renderPkg::TransparentKey;
		end
	end

	// Key colour lets the map show through
	assign shown = (spriteQ == renderPkg::TransparentKey) ? mapQ : spriteQ;
	assign blank = BlankGate && !visible;

	assign red = blank ? '0 : {shown[23:19], 3'b000};
	assign green = blank ? '0 : {shown[15:11], 3'b000};
	assign blue = blank ? '0 : {shown[7:3], 3'b000};

endmodule

`default_nettype wire

// File: source/splitScreenRenderer.sv
/* Two-player split-screen renderer, one scan position per clock.
   Outputs settle within 4 clocks of an input change. */
`timescale 1ns/1ps
`default_nettype none

module splitScreenRenderer (
	input wire logic Clk,
	input wire logic arstN,
	input renderPkg::screenCoord drawX,
	input renderPkg::screenCoord drawY,
	input renderPkg::worldCoord xOne,
	input renderPkg::worldCoord yOne,
	input renderPkg::worldCoord xTwo,
	input renderPkg::worldCoord yTwo,
	input renderPkg::facing dirOne,
	input renderPkg::facing dirTwo,
	output renderPkg::channel redOne,
	output renderPkg::channel greenOne,
	output renderPkg::channel blueOne,
	output renderPkg::channel redTwo,
	output renderPkg::channel greenTwo,
	output renderPkg::channel blueTwo
);

	renderPkg::screenCoord leadX;
	renderPkg::screenCoord leadY;
	logic visible;
	renderPkg::tileIndex tileIdx;
	renderPkg::texelAddr texel;
	renderPkg::spriteAddr spriteIdx;
	renderPkg::facing dir;
	renderPkg::rgbColor terrainColor;
	renderPkg::rgbColor spriteColor;

	fetchIf reqOne ();
	fetchIf reqTwo ();
	pixelIf pixOne ();
	pixelIf pixTwo ();

	pixelLead lead (.Clk(Clk), .arstN(arstN), .drawX(drawX), .drawY(drawY),
		.leadX(leadX), .leadY(leadY), .visible(visible));

	viewportMapper mapOne (.playerX(xOne), .playerY(yOne), .dir(dirOne),
		.leadX(leadX), .leadY(leadY), .req(reqOne.mapper));
	viewportMapper mapTwo (.playerX(xTwo), .playerY(yTwo), .dir(dirTwo),
		.leadX(leadX), .leadY(leadY), .req(reqTwo.mapper));

	viewSequencer sequencer (.Clk(Clk), .arstN(arstN),
		.viewOne(reqOne.sequencer), .viewTwo(reqTwo.sequencer),
		.tileIdx(tileIdx), .texel(texel), .spriteIdx(spriteIdx), .dir(dir),
		.terrainColor(terrainColor), .spriteColor(spriteColor),
		.outOne(pixOne.sequencer), .outTwo(pixTwo.sequencer));

	terrainRom terrain (.Clk(Clk), .tileIdx(tileIdx), .texel(texel), .color(terrainColor));

	spriteRom sprite (.Clk(Clk), .spriteIdx(spriteIdx), .dir(dir), .color(spriteColor));

	// Only view two is blanked during horizontal blanking
	pixelComposer #(.BlankGate(1'b0)) composeOne (.Clk(Clk), .arstN(arstN),
		.pix(pixOne.composer), .visible(visible),
		.red(redOne), .green(greenOne), .blue(blueOne));
	pixelComposer #(.BlankGate(1'b1)) composeTwo (.Clk(Clk), .arstN(arstN),
		.pix(pixTwo.composer), .visible(visible),
		.red(redTwo), .green(greenTwo), .blue(blueTwo));

endmodule

`default_nettype wire

// File: test/splitScreenTb.sv
/* Directed and seeded random tests for the split-screen renderer.
   Each case holds its inputs for 6 clocks before the outputs are compared. */
`timescale 1ns/1ps
`default_nettype none

module splitScreenTb;

	localparam int ClockPeriod = 100;
	localparam int DriveDelay = 10;
	localparam int SettleClocks = 6;
	localparam int TestCount = 49;
	localparam int WatchdogClocks = TestCount * 10 + 100;

	logic Clk;
	logic arstN;
	renderPkg::screenCoord drawX;
	renderPkg::screenCoord drawY;
	renderPkg::worldCoord xOne;
	renderPkg::worldCoord yOne;
	renderPkg::worldCoord xTwo;
	renderPkg::worldCoord yTwo;
	renderPkg::facing dirOne;
	renderPkg::facing dirTwo;
	renderPkg::channel redOne;
	renderPkg::channel greenOne;
	renderPkg::channel blueOne;
	renderPkg::channel redTwo;
	renderPkg::channel greenTwo;
	renderPkg::channel blueTwo;

	integer seed = 32'hd7c7_ff47;
	int errorCount = 0;
	int checkCount = 0;

	splitScreenRenderer dut (
		.Clk(Clk), .arstN(arstN), .drawX(drawX), .drawY(drawY),
		.xOne(xOne), .yOne(yOne), .xTwo(xTwo), .yTwo(yTwo),
		.dirOne(dirOne), .dirTwo(dirTwo),
		.redOne(redOne), .greenOne(greenOne), .blueOne(blueOne),
		.redTwo(redTwo), .greenTwo(greenTwo), .blueTwo(blueTwo)
	);

	initial
		Clk = 1'b0;

	always #(ClockPeriod / 2) Clk = ~Clk;

	// Reference colour of one view before the 5-bit cut
	function automatic renderPkg::rgbColor expectedPixel(input int dx, input int dy,
		input int px, input int py, input renderPkg::facing d);
		int lx;
		int ly;
		int wx;
		int wy;
		int row;
		int col;
		renderPkg::rgbColor base;
		renderPkg::rgbColor mapColor;
		lx = (dx + renderPkg::LeadX) % renderPkg::LineLength;
		ly = (dy + renderPkg::LeadY) % renderPkg::FrameLines;
		wx = (px - renderPkg::HalfViewX + lx) & 4095;
		wy = (py - renderPkg::HalfViewY + ly) & 4095;
		mapColor = '0;
		if (wx >= 32 && wx < 3168 && wy >= 32 && wy < 2368)
		begin
			case ((wx / 32 + wy / 32) % 3)
				0: base = 24'h20a040;
				1: base = 24'h2040c0;
				default: base = 24'hc0b060;
			endcase
			// Odd texels take each byte at half value
			if (((wx % 32) + (wy % 32)) % 2 == 1)
				base = {1'b0, base[23:17], 1'b0, base[15:9], 1'b0, base[7:1]};
			mapColor = base;
		end
		if (lx > 283 && lx < 357 && ly > 203 && ly < 277)
		begin
			row = ly - 203;
			col = lx - 283;
			if (row + col >= 16)
			begin
				case (d)
					renderPkg::North: return 24'hf0f0f0;
					renderPkg::South: return 24'hf04020;
					renderPkg::East: return 24'h20f040;
					default: return 24'h4020f0;
				endcase
			end
		end
		return mapColor;
	endfunction

	task automatic checkChannel(input string name, input renderPkg::channel got,
		input renderPkg::channel want);
		checkCount++;
		if (got !== want)
		begin
			errorCount++;
			$display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, want);
		end
	endtask

	task automatic checkView(input string view, input renderPkg::rgbColor want,
		input bit blanked, input renderPkg::channel r, input renderPkg::channel g,
		input renderPkg::channel b);
		renderPkg::channel er;
		renderPkg::channel eg;
		renderPkg::channel eb;
		er = blanked ? 8'h00 : (want[23:16] & 8'hf8);
		eg = blanked ? 8'h00 : (want[15:8] & 8'hf8);
		eb = blanked ? 8'h00 : (want[7:0] & 8'hf8);
		checkChannel({"red", view}, r, er);
		checkChannel({"green", view}, g, eg);
		checkChannel({"blue", view}, b, eb);
	endtask

	// Called 10 ns after a rising edge, returns at the same point of a later edge
	task automatic applyAndCheck(input int dx, input int dy, input int x1, input int y1,
		input renderPkg::facing d1, input int x2, input int y2, input renderPkg::facing d2);
		bit blanked;
		drawX = renderPkg::screenCoord'(dx);
		drawY = renderPkg::screenCoord'(dy);
		xOne = renderPkg::worldCoord'(x1);
		yOne = renderPkg::worldCoord'(y1);
		xTwo = renderPkg::worldCoord'(x2);
		yTwo = renderPkg::worldCoord'(y2);
		dirOne = d1;
		dirTwo = d2;
		repeat (SettleClocks) @(posedge Clk);
		#(DriveDelay);
		blanked = dx > 640 && dx < 799;
		checkView("One", expectedPixel(dx, dy, x1, y1, d1), 1'b0, redOne, greenOne, blueOne);
		checkView("Two", expectedPixel(dx, dy, x2, y2, d2), blanked, redTwo, greenTwo, blueTwo);
	endtask

	task automatic resetTest();
		checkView("One", '0, 1'b0, redOne, greenOne, blueOne);
		checkView("Two", '0, 1'b0, redTwo, greenTwo, blueTwo);
	endtask

	// Beam at (100, 100) looks at world (px - 218, py - 139)
	task automatic terrainTest(input int c, input int r, input int ox, input int oy);
		applyAndCheck(100, 100, 32 * c + ox + 218, 32 * r + oy + 139, renderPkg::North,
			1000, 800, renderPkg::South);
	endtask

	task automatic borderTest();
		applyAndCheck(100, 100, 228, 500, renderPkg::East, 1000, 800, renderPkg::West);
		checkView("One", '0, 1'b0, redOne, greenOne, blueOne);
		applyAndCheck(100, 100, 1000, 800, renderPkg::East, 1000, 2512, renderPkg::West);
		checkView("Two", '0, 1'b0, redTwo, greenTwo, blueTwo);
	endtask

	task automatic spriteTest(input renderPkg::facing d);
		renderPkg::facing other;
		other = renderPkg::facing'(2'(d) + 2'd1);
		applyAndCheck(318, 239, 1200, 900, d, 700, 1500, other);
	endtask

	task automatic cornerTest();
		// Lead lands on sprite row 1, column 2, inside the cut
		applyAndCheck(283, 203, 1200, 900, renderPkg::South, 700, 1500, renderPkg::West);
	endtask

	task automatic blankTest(input int dx);
		applyAndCheck(dx, 120, 1500, 1000, renderPkg::North, 900, 700, renderPkg::East);
	endtask

	task automatic randomTest(input int index);
		logic [31:0] r;
		int dx;
		int dy;
		int x1;
		int y1;
		int x2;
		int y2;
		renderPkg::facing d1;
		renderPkg::facing d2;
		r = $random(seed);
		dx = r % 800;
		r = $random(seed);
		dy = r % 525;
		if (index % 3 == 0)
		begin
			// Close to the end of the line and frame
			dx = 795 + dx % 5;
			dy = 520 + dy % 5;
		end
		r = $random(seed);
		x1 = r % 4096;
		r = $random(seed);
		y1 = r % 4096;
		r = $random(seed);
		x2 = r % 4096;
		r = $random(seed);
		y2 = r % 4096;
		r = $random(seed);
		d1 = renderPkg::facing'(r[1:0]);
		d2 = renderPkg::facing'(r[3:2]);
		applyAndCheck(dx, dy, x1, y1, d1, x2, y2, d2);
	endtask

	initial
	begin
		#(WatchdogClocks * ClockPeriod);
		$display("Timeout: the tests did not finish within %0d clocks", WatchdogClocks);
		$display("*** FAILED ***");
		$finish;
	end

	initial
	begin
		arstN = 1'b0;
		drawX = '0;
		drawY = '0;
		xOne = '0;
		yOne = '0;
		xTwo = '0;
		yTwo = '0;
		dirOne = renderPkg::North;
		dirTwo = renderPkg::North;
		repeat (2) @(posedge Clk);
		#(DriveDelay);
		arstN = 1'b1;
		resetTest();

		terrainTest(3, 3, 0, 0);
		terrainTest(3, 3, 1, 0);
		terrainTest(3, 4, 4, 6);
		terrainTest(3, 4, 5, 6);
		terrainTest(3, 5, 10, 20);
		terrainTest(3, 5, 10, 21);

		borderTest();

		spriteTest(renderPkg::North);
		spriteTest(renderPkg::South);
		spriteTest(renderPkg::East);
		spriteTest(renderPkg::West);
		cornerTest();

		blankTest(641);
		blankTest(700);
		blankTest(798);
		blankTest(640);
		blankTest(799);

		for (int i = 0; i < 30; i++)
			randomTest(i);

		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
source/renderPkg.sv
source/fetchIf.sv
source/pixelIf.sv
source/pixelLead.sv
source/viewportMapper.sv
source/viewSequencer.sv
source/terrainRom.sv
source/spriteRom.sv
source/pixelComposer.sv
source/splitScreenRenderer.sv
test/splitScreenTb.sv
